// File: cell_buf.f
src/cell_buf_pkg.sv
src/free_ptr_fifo.sv
src/cell_store.sv
src/queue_ctrl.sv
src/cell_buf_top.sv
verification/cell_buf_tb.sv

// File: Bender.yml
package:
  name: cell_buf

sources:
  - files:
      - src/cell_buf_pkg.sv
      - src/free_ptr_fifo.sv
      - src/cell_store.sv
      - src/queue_ctrl.sv
      - src/cell_buf_top.sv
  - target: test
    files:
      - verification/cell_buf_tb.sv

// File: verification/cell_buf_tb.sv
`timescale 1ns/1ps
`default_nettype none

module cell_buf_tb import cell_buf_pkg::*; ();

    typedef struct packed {
        logic [3:0] tst;
        logic       enq;
        qid_t       eq;
        logic       deq;
        qid_t       dq;
        logic       rnd;
    } stim_row_t;

    logic                  clk;
    logic                  rst_n;
    logic                  enq;
    qid_t                  enq_qid;
    cell_data_t            enq_data;
    logic                  enq_ready;
    logic                  deq;
    qid_t                  deq_qid;
    logic                  out_valid;
    cell_data_t            out_data;
    logic [num_queues-1:0] q_empty;
    cell_cnt_t             free_count;

    // Reference model of the queues and the free pool
    cell_data_t model_q [num_queues][$];
    cell_data_t exp_out [$];
    int         model_free;

    stim_row_t  rows [$];
    int         cur_errs;
    int         err_total;
    int         tests_run;
    int         tests_failed;

    cell_buf_top u_cell_buf_top (
        .clk        (clk),
        .rst_n      (rst_n),
        .enq        (enq),
        .enq_qid    (enq_qid),
        .enq_data   (enq_data),
        .enq_ready  (enq_ready),
        .deq        (deq),
        .deq_qid    (deq_qid),
        .out_valid  (out_valid),
        .out_data   (out_data),
        .q_empty    (q_empty),
        .free_count (free_count)
    );

    always #10 clk = ~clk;

    initial begin
        clk      = 1'b0;
        rst_n    = 1'b0;
        enq      = 1'b0;
        enq_qid  = '0;
        enq_data = '0;
        deq      = 1'b0;
        deq_qid  = '0;
        repeat (4) @(posedge clk);
        rst_n <= 1'b1;
    end

    //////////////////////////////
    // Checking helpers
    //////////////////////////////
    task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
        assert (got === exp) else begin
            $display("error at %0d ns: %s is %0h, expected %0h", $time, name, got, exp);
            cur_errs++;
            err_total++;
        end
    endtask

    function automatic logic [num_queues-1:0] model_empty();
        logic [num_queues-1:0] m;
        for (int q = 0; q < num_queues; q++) begin
            m[q] = (model_q[q].size() == 0);
        end
        return m;
    endfunction

    task automatic check_state();
        cell_data_t want;
        check_val("free_count", 32'(free_count), 32'(model_free));
        check_val("q_empty", 32'(q_empty), 32'(model_empty()));
        check_val("enq_ready", 32'(enq_ready), 32'(model_free != 0));
        if (exp_out.size() != 0) begin
            want = exp_out.pop_front();
            check_val("out_valid", 32'(out_valid), 32'd1);
            check_val("out_data", out_data, want);
        end else begin
            check_val("out_valid", 32'(out_valid), 32'd0);
        end
    endtask

    // Accept rules use the state before the edge
    task automatic step_model(input stim_row_t r, input cell_data_t d);
        logic enq_ok;
        logic deq_ok;
        enq_ok = r.enq && (model_free != 0);
        deq_ok = r.deq && (model_q[r.dq].size() != 0);
        if (deq_ok) begin
            exp_out.push_back(model_q[r.dq].pop_front());
        end
        if (enq_ok) begin
            model_q[r.eq].push_back(d);
        end
        model_free = model_free - int'(enq_ok) + int'(deq_ok);
    endtask

    function automatic string test_name(input int t);
        case (t)
            1:       return "after reset";
            2:       return "fifo order";
            3:       return "full pool";
            4:       return "empty queue";
            5:       return "same-cycle enq and deq";
            default: return "cell reuse";
        endcase
    endfunction

    task automatic report_test(input int t);
        tests_run++;
        if (cur_errs == 0) begin
            $display("test %0d (%s): ok", t, test_name(t));
        end else begin
            $display("test %0d (%s): FAILED with %0d errors", t, test_name(t), cur_errs);
            tests_failed++;
        end
        cur_errs = 0;
    endtask

    //////////////////////////////
    // Stimulus table
    //////////////////////////////
    task automatic add_row(input int t, input logic e, input int eq, input logic d,
                           input int dq, input logic rnd);
        stim_row_t r;
        r.tst = t[3:0];
        r.enq = e;
        r.eq  = qid_t'(eq);
        r.deq = d;
        r.dq  = qid_t'(dq);
        r.rnd = rnd;
        rows.push_back(r);
    endtask

    task automatic build_table();
        // Interleaved over all four queues and then drained
        for (int k = 0; k < 8; k++) begin
            add_row(2, 1, k % 4, 0, 0, 0);
        end
        for (int k = 0; k < 8; k++) begin
            add_row(2, 0, 0, 1, k % 4, 0);
        end
        // Whole pool into q0 and q1 plus one enq too many
        for (int k = 0; k < 16; k++) begin
            add_row(3, 1, k / 8, 0, 0, 1);
        end
        add_row(3, 1, 2, 0, 0, 1);
        add_row(4, 0, 0, 1, 2, 0);
        add_row(4, 0, 0, 1, 3, 0);
        add_row(5, 0, 0, 1, 0, 0);
        add_row(5, 1, 0, 1, 0, 1);
        add_row(5, 1, 2, 1, 1, 1);
        // q2 holds a single cell here
        add_row(5, 1, 2, 1, 2, 1);
        add_row(5, 1, 2, 1, 2, 1);
        // Empty q3 takes the last cell and the next enq is blocked
        add_row(5, 1, 3, 1, 3, 1);
        add_row(5, 1, 3, 1, 3, 1);
        add_row(5, 0, 0, 1, 2, 0);
        for (int k = 0; k < 14; k++) begin
            add_row(6, 0, 0, 1, k % 2, 0);
        end
        for (int k = 0; k < 16; k++) begin
            add_row(6, 1, k % 4, 0, 0, 1);
        end
        for (int k = 0; k < 16; k++) begin
            add_row(6, 0, 0, 1, 3 - (k % 4), 0);
        end
    endtask

    //////////////////////////////
    // Table walk
    //////////////////////////////
    task automatic run_table();
        logic       last;
        stim_row_t  cur;
        cell_data_t cur_data;

        cur      = '0;
        cur_data = '0;

        @(negedge clk);
        check_state();
        report_test(1);

        // Row i is driven while row i-1 is checked
        for (int i = 0; i <= rows.size(); i++) begin
            @(posedge clk);
            if (i < rows.size()) begin
                cur      = rows[i];
                cur_data = cur.rnd ? $urandom : (32'hc0de_0000 | 32'(i));
                enq      <= cur.enq;
                enq_qid  <= cur.eq;
                enq_data <= cur_data;
                deq      <= cur.deq;
                deq_qid  <= cur.dq;
            end else begin
                enq <= 1'b0;
                deq <= 1'b0;
            end
            @(negedge clk);
            if (i > 0) begin
                check_state();
                last = (i == rows.size());
                if (!last) begin
                    last = (rows[i].tst != rows[i-1].tst);
                end
                if (last) begin
                    report_test(int'(rows[i-1].tst));
                end
            end
            if (i < rows.size()) begin
                step_model(cur, cur_data);
            end
        end
    endtask

    //////////////////////////////
    // Main sequence
    //////////////////////////////
    initial begin
        int seed_ret;
        int waited;

        seed_ret     = $urandom(32'h861526ab);
        model_free   = num_cells;
        cur_errs     = 0;
        err_total    = 0;
        tests_run    = 0;
        tests_failed = 0;
        build_table();

        waited = 0;
        while (rst_n !== 1'b1 && waited < 10) begin
            @(posedge clk);
            waited++;
        end

        if (rst_n !== 1'b1) begin
            $display("timed out waiting for reset release");
            $display("Some tests failed");
        end else begin
            run_table();
            $display("%0d tests run, %0d failed, %0d check errors", tests_run, tests_failed,
                     err_total);
            if (tests_failed == 0) begin
                $display("All tests passed");
            end else begin
                $display("Some tests failed");
            end
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: src/cell_buf_top.sv
`timescale 1ns/1ps
`default_nettype none

module cell_buf_top import cell_buf_pkg::*; (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  enq,
    input  qid_t                  enq_qid,
    input  cell_data_t            enq_data,
    output logic                  enq_ready,
    input  logic                  deq,
    input  qid_t                  deq_qid,
    output logic                  out_valid,
    output cell_data_t            out_data,
    output logic [num_queues-1:0] q_empty,
    output cell_cnt_t             free_count
);

    // Free list links
    logic       fl_rd;
    logic       fl_wr;
    cell_addr_t fl_wdata;
    cell_addr_t fl_rdata;
    logic       fl_empty;

    // Cell store links
    logic       wr_en;
    cell_addr_t wr_addr;
    cell_data_t wr_data;
    logic       link_en;
    cell_addr_t link_addr;
    cell_addr_t link_next;
    logic       rd_en;
    cell_addr_t rd_addr;
    cell_addr_t next_of;

    //////////////////////////////
    // Free address list
    //////////////////////////////
    free_ptr_fifo u_free_ptr_fifo (
        .clk    (clk),
        .rst_n  (rst_n),
        .rd     (fl_rd),
        .wr     (fl_wr),
        .w_data (fl_wdata),
        .r_data (fl_rdata),
        .empty  (fl_empty),
        .full   (),
        .count  (free_count)
    );

    //////////////////////////////
    // Payload and links
    //////////////////////////////
    cell_store u_cell_store (
        .clk       (clk),
        .rst_n     (rst_n),
        .wr_en     (wr_en),
        .wr_addr   (wr_addr),
        .wr_data   (wr_data),
        .link_en   (link_en),
        .link_addr (link_addr),
        .link_next (link_next),
        .rd_en     (rd_en),
        .rd_addr   (rd_addr),
        .rd_data   (out_data),
        .next_of   (next_of)
    );

    //////////////////////////////
    // Queue bookkeeping
    //////////////////////////////
    queue_ctrl u_queue_ctrl (
        .clk       (clk),
        .rst_n     (rst_n),
        .enq       (enq),
        .enq_qid   (enq_qid),
        .enq_data  (enq_data),
        .deq       (deq),
        .deq_qid   (deq_qid),
        .enq_ready (enq_ready),
        .q_empty   (q_empty),
        .out_valid (out_valid),
        .fl_rd     (fl_rd),
        .fl_wr     (fl_wr),
        .fl_wdata  (fl_wdata),
        .fl_rdata  (fl_rdata),
        .fl_empty  (fl_empty),
        .wr_en     (wr_en),
        .wr_addr   (wr_addr),
        .wr_data   (wr_data),
        .link_en   (link_en),
        .link_addr (link_addr),
        .link_next (link_next),
        .rd_en     (rd_en),
        .rd_addr   (rd_addr),
        .next_of   (next_of)
    );

endmodule

`default_nettype wire

// File: src/queue_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module queue_ctrl import cell_buf_pkg::*; (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  enq,
    input  qid_t                  enq_qid,
    input  cell_data_t            enq_data,
    input  logic                  deq,
    input  qid_t                  deq_qid,
    output logic                  enq_ready,
    output logic [num_queues-1:0] q_empty,
    output logic                  out_valid,
    // Free list
    output logic                  fl_rd,
    output logic                  fl_wr,
    output cell_addr_t            fl_wdata,
    input  cell_addr_t            fl_rdata,
    input  logic                  fl_empty,
    // Cell store
    output logic                  wr_en,
    output cell_addr_t            wr_addr,
    output cell_data_t            wr_data,
    output logic                  link_en,
    output cell_addr_t            link_addr,
    output cell_addr_t            link_next,
    output logic                  rd_en,
    output cell_addr_t            rd_addr,
    input  cell_addr_t            next_of
);

    cell_addr_t q_head [num_queues];
    cell_addr_t q_tail [num_queues];
    cell_cnt_t  q_len  [num_queues];

    logic                  enq_acc;
    logic                  deq_acc;
    logic [num_queues-1:0] enq_hit;
    logic [num_queues-1:0] deq_hit;

    //////////////////////////////
    // Accept decisions
    //////////////////////////////
    assign enq_ready = ~fl_empty;
    assign enq_acc   = enq & ~fl_empty;
    assign deq_acc   = deq & (q_len[deq_qid] != '0);

    always_comb begin
        for (int q = 0; q < num_queues; q++) begin
            enq_hit[q] = enq_acc && (enq_qid == qid_t'(q));
            deq_hit[q] = deq_acc && (deq_qid == qid_t'(q));
            q_empty[q] = (q_len[q] == '0);
        end
    end

    //////////////////////////////
    // Memory and free list
    //////////////////////////////

    // New cell comes straight off the free list
    assign fl_rd   = enq_acc;
    assign wr_en   = enq_acc;
    assign wr_addr = fl_rdata;
    assign wr_data = enq_data;

    // Append behind the old tail unless the queue is empty
    assign link_en   = enq_acc && (q_len[enq_qid] != '0);
    assign link_addr = q_tail[enq_qid];
    assign link_next = fl_rdata;

    // Head cell is read out and handed back in the same cycle
    assign rd_en    = deq_acc;
    assign rd_addr  = q_head[deq_qid];
    assign fl_wr    = deq_acc;
    assign fl_wdata = q_head[deq_qid];

    //////////////////////////////
    // Per-queue state
    //////////////////////////////
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int q = 0; q < num_queues; q++) begin
                q_head[q] <= '0;
                q_tail[q] <= '0;
                q_len[q]  <= '0;
            end
        end else begin
            for (int q = 0; q < num_queues; q++) begin
                case ({enq_hit[q], deq_hit[q]})
                    2'b10: begin
                        q_tail[q] <= fl_rdata;
                        q_len[q]  <= q_len[q] + 1'b1;
                        if (q_len[q] == '0) begin
                            q_head[q] <= fl_rdata;
                        end
                    end
                    2'b01: begin
                        q_head[q] <= next_of;
                        q_len[q]  <= q_len[q] - 1'b1;
                    end
                    2'b11: begin
                        // Length stays, only the single cell is swapped
                        q_tail[q] <= fl_rdata;
                        if (q_len[q] == cell_cnt_t'(1)) begin
                            q_head[q] <= fl_rdata;
                        end else begin
                            q_head[q] <= next_of;
                        end
                    end
                    default: begin
                    end
                endcase
            end
        end
    end

    // Data arrives from the store one cycle after the accept
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= deq_acc;
        end
    end

    for (genvar g = 0; g < num_queues; g++) begin : g_len_chk
        a_len_max: assert property (@(posedge clk) disable iff (!rst_n)
            q_len[g] <= cell_cnt_t'(num_cells))
            else $error("queue %0d length %0d over pool size", g, q_len[g]);
    end

endmodule

`default_nettype wire

// File: src/cell_store.sv
`timescale 1ns/1ps
`default_nettype none

module cell_store import cell_buf_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       wr_en,
    input  cell_addr_t wr_addr,
    input  cell_data_t wr_data,
    input  logic       link_en,
    input  cell_addr_t link_addr,
    input  cell_addr_t link_next,
    input  logic       rd_en,
    input  cell_addr_t rd_addr,
    output cell_data_t rd_data,
    output cell_addr_t next_of
);

    cell_data_t data_mem [num_cells];
    cell_addr_t next_mem [num_cells];

    //////////////////////////////
    // Payload with registered read
    //////////////////////////////
    always_ff @(posedge clk) begin
        if (wr_en) begin
            data_mem[wr_addr] <= wr_data;
        end
        if (rd_en) begin
            rd_data <= data_mem[rd_addr];
        end
    end

    //////////////////////////////
    // Next-pointer table
    //////////////////////////////
    always_ff @(posedge clk) begin
        if (link_en) begin
            next_mem[link_addr] <= link_next;
        end
    end

    // Successor of the cell being read, seen in the same cycle
    assign next_of = next_mem[rd_addr];

    // Enqueue writes a free cell while dequeue reads a queued one
    a_rd_wr_apart: assert property (@(posedge clk) disable iff (!rst_n)
        !(rd_en && wr_en && rd_addr == wr_addr))
        else $error("cell %0d read and written in one cycle", rd_addr);

endmodule

`default_nettype wire

// File: src/free_ptr_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module free_ptr_fifo import cell_buf_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       rd,
    input  logic       wr,
    input  cell_addr_t w_data,
    output cell_addr_t r_data,
    output logic       empty,
    output logic       full,
    output cell_cnt_t  count
);

    cell_addr_t ptr_mem [num_cells];

    cell_addr_t w_ptr, w_ptr_n, w_ptr_succ;
    cell_addr_t r_ptr, r_ptr_n, r_ptr_succ;
    cell_cnt_t  count_r, count_n;
    logic       full_r, full_n;
    logic       empty_r, empty_n;
    logic       mem_we;

    //////////////////////////////
    // Address storage
    //////////////////////////////

    // Slot under w_ptr is also the one being read when full
    assign mem_we = wr & (~full_r | rd);

    // Reset rebuilds the free list as 0 .. num_cells-1
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < num_cells; i++) begin
                ptr_mem[i] <= cell_addr_t'(i);
            end
        end else if (mem_we) begin
            ptr_mem[w_ptr] <= w_data;
        end
    end

    assign r_data = ptr_mem[r_ptr];

    //////////////////////////////
    // Pointers and flags
    //////////////////////////////
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            w_ptr   <= '0;
            r_ptr   <= '0;
            full_r  <= 1'b1;
            empty_r <= 1'b0;
            count_r <= cell_cnt_t'(num_cells);
        end else begin
            w_ptr   <= w_ptr_n;
            r_ptr   <= r_ptr_n;
            full_r  <= full_n;
            empty_r <= empty_n;
            count_r <= count_n;
        end
    end

    always_comb begin
        w_ptr_succ = w_ptr + 1'b1;
        r_ptr_succ = r_ptr + 1'b1;
        w_ptr_n    = w_ptr;
        r_ptr_n    = r_ptr;
        full_n     = full_r;
        empty_n    = empty_r;
        count_n    = count_r;

        case ({rd, wr})
            2'b01: begin
                if (!full_r) begin
                    w_ptr_n = w_ptr_succ;
                    count_n = count_r + 1'b1;
                    empty_n = 1'b0;
                    full_n  = (w_ptr_succ == r_ptr);
                end
            end
            2'b10: begin
                if (!empty_r) begin
                    r_ptr_n = r_ptr_succ;
                    count_n = count_r - 1'b1;
                    full_n  = 1'b0;
                    empty_n = (r_ptr_succ == w_ptr);
                end
            end
            // One address out and one back, occupancy unchanged
            2'b11: begin
                w_ptr_n = w_ptr_succ;
                r_ptr_n = r_ptr_succ;
            end
            default: begin
            end
        endcase
    end

    assign full  = full_r;
    assign empty = empty_r;
    assign count = count_r;

    // Flags and counter must agree
    a_full_count: assert property (@(posedge clk) disable iff (!rst_n)
        full |-> count == cell_cnt_t'(num_cells))
        else $error("free list full with count %0d", count);

    a_empty_count: assert property (@(posedge clk) disable iff (!rst_n)
        empty |-> count == '0)
        else $error("free list empty with count %0d", count);

endmodule

`default_nettype wire

// File: src/cell_buf_pkg.sv
`default_nettype none

package cell_buf_pkg;

    //////////////////////////////
    // Pool and queue sizes
    //////////////////////////////
    localparam int num_cells  = 16;
    localparam int num_queues = 4;
    localparam int data_w     = 32;

    // Derived widths
    localparam int addr_w = $clog2(num_cells);
    localparam int cnt_w  = $clog2(num_cells + 1);
    localparam int qid_w  = $clog2(num_queues);

    //////////////////////////////
    // Vector types
    //////////////////////////////
    typedef logic [addr_w-1:0] cell_addr_t;

    // Must reach num_cells itself
    typedef logic [cnt_w-1:0]  cell_cnt_t;

    typedef logic [qid_w-1:0]  qid_t;
    typedef logic [data_w-1:0] cell_data_t;

endpackage

`default_nettype wire
